//--- pc_enc_settings.svh
// polar encoder sizes, tag width and information position mask
`ifndef PC_ENC_SETTINGS_SVH
`define PC_ENC_SETTINGS_SVH

// ----------------------------
// code geometry
// ----------------------------

// log2 of code length, also the number of kernel stages
`define PC_ADDR_W 4
// code length in bits
`define PC_N (1 << `PC_ADDR_W)
// information bits per frame
`define PC_K 8

// ----------------------------
// frame attributes
// ----------------------------

`define PC_TAG_W 4
// set bit marks an information position, exactly PC_K bits set
// remaining positions are frozen to zero
`define PC_INFO_MASK 16'hFE80

`endif

//--- pc_enc_code_pkg.sv
// code-side types: frame vector, frame tag, buffer address, tagged frame
`include "pc_enc_settings.svh"

package pc_enc_code_pkg;

  // ----------------------------
  // scalar types
  // ----------------------------

  // bit i is position i of u before the kernel and of x after it
  typedef logic [`PC_N-1:0] frame_t;

  // frame tag, travels with the frame through both buffers
  typedef logic [`PC_TAG_W-1:0] tag_t;

  // buffer word address, one code bit per word
  typedef logic [`PC_ADDR_W-1:0] addr_t;

  // ----------------------------
  // source to transform
  // ----------------------------

  // placed information vector plus its tag
  // frozen positions already zero here
  typedef struct packed {
    frame_t vec;
    tag_t   tag;
  } vec_frame_t;

endpackage

//--- pc_enc_strm_pkg.sv
// stream-side structs: serial information input and coded frame output
package pc_enc_strm_pkg;

  import pc_enc_code_pkg::*;

  // ----------------------------
  // input bit stream
  // ----------------------------

  // one information bit per val beat
  // tag only meaningful on the sop beat
  typedef struct packed {
    logic sop;
    logic val;
    logic eop;
    logic dat;
    tag_t tag;
  } in_strm_t;

  // ----------------------------
  // output coded stream
  // ----------------------------

  // one code bit per val beat, N beats per frame
  // tag held for the whole frame
  typedef struct packed {
    logic sop;
    logic val;
    logic eop;
    logic dat;
    tag_t tag;
  } out_strm_t;

endpackage

//--- pc_enc_source.sv
// polar encoder source: information bit placement and frame strobe
`include "pc_enc_settings.svh"

module pc_enc_source
  import pc_enc_code_pkg::*;
  import pc_enc_strm_pkg::*;
(
  input  logic       iclk,
  input  logic       ireset,
  input  logic       iclkena,
  input  in_strm_t   istrm,
  input  logic       itaken,
  output logic       ordy,
  output logic       ostrb,
  output vec_frame_t oframe
);

  localparam frame_t INFO_MASK = `PC_INFO_MASK;

  // ----------------------------
  // information position walk
  // ----------------------------

  // lowest set position of the mask
  function automatic addr_t first_info_pos();
    addr_t r;
    r = '0;
    for (int i = `PC_N - 1; i >= 0; i--) begin
      if (INFO_MASK[i]) begin
        r = addr_t'(i);
      end
    end
    return r;
  endfunction

  // next set position above p, p itself if there is none
  function automatic addr_t next_info_pos(addr_t p);
    addr_t r;
    r = p;
    for (int i = `PC_N - 1; i >= 0; i--) begin
      if ((i > int'(p)) && INFO_MASK[i]) begin
        r = addr_t'(i);
      end
    end
    return r;
  endfunction

  localparam addr_t FIRST_POS = first_info_pos();

  logic       pend;
  logic       pend_nxt;
  logic       take;
  addr_t      pos;
  addr_t      cur_pos;
  vec_frame_t frm;

  // beats are dropped while a finished frame waits for the transform
  assign take     = istrm.val & ~pend;
  // sop restarts the walk at the first information position
  assign cur_pos  = istrm.sop ? FIRST_POS : pos;
  assign pend_nxt = pend ? ~itaken : (take & istrm.eop);

  // ----------------------------
  // control
  // ----------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      pend  <= 1'b0;
      ordy  <= 1'b0;
      ostrb <= 1'b0;
      pos   <= FIRST_POS;
    end else if (iclkena) begin
      pend  <= pend_nxt;
      ordy  <= ~pend_nxt;
      // strobe one tick after the eop beat
      ostrb <= take & istrm.eop;
      if (take) begin
        pos <= next_info_pos(cur_pos);
      end
    end
  end

  // frame vector and tag, frozen bits cleared on sop
  always_ff @(posedge iclk) begin
    if (iclkena && take) begin
      if (istrm.sop) begin
        frm.vec <= '0;
        frm.tag <= istrm.tag;
      end
      frm.vec[cur_pos] <= istrm.dat;
    end
  end

  // held stable until taken, no new frame starts while pending
  assign oframe = frm;

endmodule

//--- pc_enc_transform.sv
// polar encoder transform: staged kernel and serial write into the buffer
`include "pc_enc_settings.svh"

module pc_enc_transform
  import pc_enc_code_pkg::*;
(
  input  logic       iclk,
  input  logic       ireset,
  input  logic       iclkena,
  input  logic       istrb,
  input  vec_frame_t iframe,
  output logic       otaken,
  input  logic       owfree,
  output logic       owena,
  output addr_t      owaddr,
  output logic       owdat,
  output tag_t       owtag,
  output logic       owdone
);

  localparam int STAGE_W = (`PC_ADDR_W > 1) ? $clog2(`PC_ADDR_W) : 1;

  typedef enum logic [1:0] {T_IDLE, T_KERN, T_WRITE, T_DONE} state_t;

  // one butterfly stage, upper half of each pair folds into lower half
  function automatic frame_t kernel_stage(frame_t v, int s);
    frame_t r;
    r = v;
    for (int i = 0; i < `PC_N; i++) begin
      if (((i >> s) & 1) == 0) begin
        r[i] = v[i] ^ v[i + (1 << s)];
      end
    end
    return r;
  endfunction

  state_t             state;
  logic               pend;
  logic [STAGE_W-1:0] stage;
  addr_t              cnt;
  frame_t             vec;
  tag_t               tag;

  // ----------------------------
  // control FSM
  // ----------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state  <= T_IDLE;
      pend   <= 1'b0;
      otaken <= 1'b0;
      stage  <= '0;
      cnt    <= '0;
    end else if (iclkena) begin
      otaken <= 1'b0;
      // remember a strobe that came while busy
      if (istrb) begin
        pend <= 1'b1;
      end
      case (state)
        T_IDLE: begin
          if (istrb || pend) begin
            state  <= T_KERN;
            pend   <= 1'b0;
            otaken <= 1'b1;
            stage  <= '0;
          end
        end
        T_KERN: begin
          stage <= stage + 1'b1;
          if (stage == STAGE_W'(`PC_ADDR_W - 1)) begin
            state <= T_WRITE;
            cnt   <= '0;
          end
        end
        // stall at address 0 until a write bank frees up
        T_WRITE: begin
          if (owfree) begin
            cnt <= cnt + 1'b1;
            if (cnt == addr_t'(`PC_N - 1)) begin
              state <= T_DONE;
            end
          end
        end
        default: state <= T_IDLE;
      endcase
    end
  end

  // working vector, loaded on take and folded once per kernel tick
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (state == T_IDLE && (istrb || pend)) begin
        vec <= iframe.vec;
        tag <= iframe.tag;
      end else if (state == T_KERN) begin
        vec <= kernel_stage(vec, int'(stage));
      end
    end
  end

  // ----------------------------
  // buffer write port
  // ----------------------------

  assign owena  = (state == T_WRITE) & owfree;
  assign owaddr = cnt;
  assign owdat  = vec[cnt];
  assign owtag  = tag;
  assign owdone = (state == T_DONE);

endmodule

//--- pc_enc_buffer.sv
// polar encoder buffer: two-bank ping-pong memory with full flags
`include "pc_enc_settings.svh"

module pc_enc_buffer
  import pc_enc_code_pkg::*;
#(
  parameter type payload_t = logic
)
(
  input  logic     iclk,
  input  logic     ireset,
  input  logic     iclkena,
  input  logic     iwena,
  input  addr_t    iwaddr,
  input  payload_t iwdat,
  input  logic     iwdone,
  output logic     owfree,
  input  addr_t    iraddr,
  output payload_t ordat,
  output logic     ofull,
  input  logic     irempty
);

  // bank pointers and per-bank full flags
  typedef struct packed {
    logic       wbank;
    logic       rbank;
    logic [1:0] full;
  } bank_ctl_t;

  bank_ctl_t ctl;
  payload_t  mem [2][`PC_N];

  // ----------------------------
  // bank handshake
  // ----------------------------

  assign owfree = ~ctl.full[ctl.wbank];
  assign ofull  = ctl.full[ctl.rbank];

  // writer fills one bank while the reader drains the other
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ctl <= '0;
    end else if (iclkena) begin
      // write done marks the bank full and moves to the other one
      if (iwdone) begin
        ctl.full[ctl.wbank] <= 1'b1;
        ctl.wbank           <= ~ctl.wbank;
      end
      // last read frees the bank
      if (irempty) begin
        ctl.full[ctl.rbank] <= 1'b0;
        ctl.rbank           <= ~ctl.rbank;
      end
    end
  end

  // ----------------------------
  // memory
  // ----------------------------

  // registered read, first tick of the sink read latency
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (iwena) begin
        mem[ctl.wbank][iwaddr] <= iwdat;
      end
      ordat <= mem[ctl.rbank][iraddr];
    end
  end

endmodule

//--- pc_enc_sink.sv
// polar encoder sink: request driven bank read and coded frame output
`include "pc_enc_settings.svh"

module pc_enc_sink
  import pc_enc_code_pkg::*;
  import pc_enc_strm_pkg::*;
(
  input  logic      iclk,
  input  logic      ireset,
  input  logic      iclkena,
  input  logic      ifull,
  input  logic      irdat,
  input  tag_t      irtag,
  output logic      orempty,
  output addr_t     oraddr,
  input  logic      ireq,
  output logic      ofull,
  output out_strm_t ostrm
);

  typedef enum logic {S_IDLE, S_READ} state_t;

  state_t state;

  // read address plus last word flag
  struct packed {
    logic  done;
    addr_t val;
  } cnt;

  logic [1:0] val;
  logic [1:0] eop;
  // sop/full set pipeline
  logic [1:0] set_sf;
  logic       sop_hold;
  logic       start;
  logic       rd_req;
  logic       dat_q;
  tag_t       tag_q;

  // ----------------------------
  // control FSM
  // ----------------------------

  assign start   = (state == S_IDLE) & ifull;
  assign rd_req  = (state == S_READ) & ireq;
  // request that takes the last word frees the bank
  assign orempty = rd_req & cnt.done;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      state <= S_IDLE;
      cnt   <= '0;
    end else if (iclkena) begin
      case (state)
        S_IDLE: state <= ifull ? S_READ : S_IDLE;
        S_READ: state <= orempty ? S_IDLE : S_READ;
        default: state <= S_IDLE;
      endcase
      // address restarts from zero for every bank
      if (state == S_IDLE) begin
        cnt <= '0;
      end else if (ireq) begin
        cnt.val  <= cnt.val + 1'b1;
        cnt.done <= (cnt.val == addr_t'(`PC_N - 2));
      end
    end
  end

  assign oraddr = cnt.val;

  // ----------------------------
  // two tick read latency
  // ----------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      val      <= '0;
      eop      <= '0;
      set_sf   <= '0;
      ofull    <= 1'b0;
      sop_hold <= 1'b0;
    end else if (iclkena) begin
      val    <= {val[0], rd_req};
      eop    <= {eop[0], orempty};
      set_sf <= {set_sf[0], start};
      if (set_sf[1]) begin
        ofull <= 1'b1;
      end else if (orempty) begin
        ofull <= 1'b0;
      end
      // armed for the first beat of the frame
      if (set_sf[1]) begin
        sop_hold <= 1'b1;
      end else if (val[1]) begin
        sop_hold <= 1'b0;
      end
    end
  end

  // second latency tick for data
  // the tag read is registered too, so the tag is taken one tick after start
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      dat_q <= irdat;
      if (set_sf[0]) begin
        tag_q <= irtag;
      end
    end
  end

  always_comb begin
    ostrm.sop = sop_hold & val[1];
    ostrm.val = val[1];
    ostrm.eop = eop[1];
    ostrm.dat = dat_q;
    ostrm.tag = tag_q;
  end

endmodule

//--- pc_enc_top.sv
// polar encoder top: source, transform, bit and tag buffers, sink
module pc_enc_top
  import pc_enc_code_pkg::*;
  import pc_enc_strm_pkg::*;
(
  input  logic      iclk,
  input  logic      ireset,
  input  logic      iclkena,
  input  in_strm_t  istrm,
  output logic      ordy,
  input  logic      ireq,
  output logic      ofull,
  output out_strm_t ostrm
);

  // ----------------------------
  // internal wires
  // ----------------------------

  // source to transform
  logic       frame_strb;
  logic       taken;
  vec_frame_t frame;

  // transform to buffers
  logic       wfree;
  logic       wena;
  addr_t      waddr;
  logic       wdat;
  tag_t       wtag;
  logic       wdone;

  // buffers to sink
  logic       rfull;
  addr_t      raddr;
  logic       rdat;
  tag_t       rtag;
  logic       rempty;

  pc_enc_source u_source (
    .iclk   (iclk),
    .ireset (ireset),
    .iclkena(iclkena),
    .istrm  (istrm),
    .itaken (taken),
    .ordy   (ordy),
    .ostrb  (frame_strb),
    .oframe (frame)
  );

  pc_enc_transform u_transform (
    .iclk   (iclk),
    .ireset (ireset),
    .iclkena(iclkena),
    .istrb  (frame_strb),
    .iframe (frame),
    .otaken (taken),
    .owfree (wfree),
    .owena  (wena),
    .owaddr (waddr),
    .owdat  (wdat),
    .owtag  (wtag),
    .owdone (wdone)
  );

  // code bit banks, drive the bank handshake
  pc_enc_buffer #(.payload_t(logic)) u_bit_buf (
    .iclk(iclk), .ireset(ireset), .iclkena(iclkena),
    .iwena(wena), .iwaddr(waddr), .iwdat(wdat), .iwdone(wdone), .owfree(wfree),
    .iraddr(raddr), .ordat(rdat), .ofull(rfull), .irempty(rempty)
  );

  // tag banks move in lockstep, only word 0 is used
  pc_enc_buffer #(.payload_t(tag_t)) u_tag_buf (
    .iclk(iclk), .ireset(ireset), .iclkena(iclkena),
    .iwena(wena), .iwaddr('0), .iwdat(wtag), .iwdone(wdone), .owfree(),
    .iraddr('0), .ordat(rtag), .ofull(), .irempty(rempty)
  );

  pc_enc_sink u_sink (
    .iclk   (iclk),
    .ireset (ireset),
    .iclkena(iclkena),
    .ifull  (rfull),
    .irdat  (rdat),
    .irtag  (rtag),
    .orempty(rempty),
    .oraddr (raddr),
    .ireq   (ireq),
    .ofull  (ofull),
    .ostrm  (ostrm)
  );

endmodule

//--- pc_enc_sva.sv
// encoder top checks: reset values, output framing, request before data
`include "pc_enc_settings.svh"

module pc_enc_sva
  import pc_enc_strm_pkg::*;
(
  input logic      iclk,
  input logic      ireset,
  input logic      iclkena,
  input logic      ordy,
  input logic      ireq,
  input logic      ofull,
  input out_strm_t ostrm
);

  int unsigned req_cnt;
  int unsigned beat_cnt;
  // beat position inside the current frame
  int unsigned pos;
  logic        beat;

  assign beat = iclkena & ostrm.val;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      req_cnt  <= 0;
      beat_cnt <= 0;
      pos      <= 0;
    end else begin
      if (iclkena && ireq) begin
        req_cnt <= req_cnt + 1;
      end
      if (beat) begin
        beat_cnt <= beat_cnt + 1;
        pos      <= ostrm.eop ? 0 : pos + 1;
      end
    end
  end

  // outputs quiet through reset and on the first edge after it
  a_reset_quiet: assert property (@(posedge iclk)
    $past(ireset) |-> !ofull && !ordy && !ostrm.val && !ostrm.sop && !ostrm.eop)
    else $error("outputs not idle after reset");

  // sop exactly on the first beat, eop exactly on the N-th
  a_sop_first: assert property (@(posedge iclk) disable iff (ireset)
    beat |-> (ostrm.sop == (pos == 0)))
    else $error("sop not on first beat of frame");

  a_eop_last: assert property (@(posedge iclk) disable iff (ireset)
    beat |-> (ostrm.eop == (pos == `PC_N - 1)))
    else $error("eop not on last beat of frame");

  a_req_first: assert property (@(posedge iclk) disable iff (ireset)
    beat |-> (beat_cnt < req_cnt))
    else $error("output beat without an earlier request");

endmodule

bind pc_enc_top pc_enc_sva u_sva (
  .iclk   (iclk),
  .ireset (ireset),
  .iclkena(iclkena),
  .ordy   (ordy),
  .ireq   (ireq),
  .ofull  (ofull),
  .ostrm  (ostrm)
);

//--- tb_pc_enc.sv
// polar encoder testbench: clock, reset, LFSR stimulus, reference model, checks, watchdog
`include "pc_enc_settings.svh"

module tb_pc_enc
  import pc_enc_code_pkg::*;
  import pc_enc_strm_pkg::*;
();

  localparam int N_RAND          = 24;
  localparam int N_HOLD          = 4;
  localparam int N_FRAMES        = 2 + N_RAND + N_HOLD;
  // generous bound on cycles per frame, serial worst case
  localparam int FRAME_CYCLES    = 300;
  localparam int HOLD_TICKS      = 120;
  localparam int WATCHDOG_CYCLES = N_FRAMES * FRAME_CYCLES + HOLD_TICKS + 20;
  localparam logic [31:0] SEED   = 32'hdb02ee56;
  localparam frame_t INFO_MASK   = `PC_INFO_MASK;

  typedef logic [`PC_K-1:0] info_t;

  logic        iclk;
  logic        ireset;
  logic        iclkena;
  logic        ireq;
  logic        ordy;
  logic        ofull;
  in_strm_t    istrm;
  out_strm_t   ostrm;

  logic [31:0] lfsr = SEED;
  logic        en_seen;
  logic        hold_req;
  int          errors = 0;
  int          frames_in = 0;
  int          frames_out = 0;
  int          beat_idx = 0;
  frame_t      got_vec;
  frame_t      exp_frames[$];
  tag_t        exp_tags[$];

  pc_enc_top dut (
    .iclk   (iclk),
    .ireset (ireset),
    .iclkena(iclkena),
    .istrm  (istrm),
    .ordy   (ordy),
    .ireq   (ireq),
    .ofull  (ofull),
    .ostrm  (ostrm)
  );

  always #50 iclk = ~iclk;

  // ------------------------------
  // random source
  // ------------------------------

  // right shifting Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  // one LFSR step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // ------------------------------
  // reference model
  // ------------------------------

  // k-th information bit onto the k-th set mask position
  function automatic frame_t place_bits(info_t bits);
    frame_t u;
    int     k;
    u = '0;
    k = 0;
    for (int i = 0; i < `PC_N; i++) begin
      if (INFO_MASK[i]) begin
        u[i] = bits[k];
        k++;
      end
    end
    return u;
  endfunction

  // stage s folds the upper half of every 2^(s+1) block into its lower half
  function automatic frame_t polar_encode(frame_t u);
    frame_t x;
    int     span;
    x = u;
    for (int s = 0; s < `PC_ADDR_W; s++) begin
      span = 1 << s;
      for (int blk = 0; blk < `PC_N; blk += 2 * span) begin
        for (int j = 0; j < span; j++) begin
          x[blk + j] = x[blk + j] ^ x[blk + j + span];
        end
      end
    end
    return x;
  endfunction

  // ------------------------------
  // failure and compare
  // ------------------------------

  task automatic abort_run(string why);
    errors++;
    $display("%s", why);
    $display("** FAIL **");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_frame(frame_t got, frame_t exp, string name);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_tag(tag_t got, tag_t exp, string name);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(logic got, logic exp, string name);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------

  // one clock edge, en_seen is the enable the DUT used on it
  task automatic tick();
    @(posedge iclk);
    en_seen = iclkena;
    iclkena <= (rand_bits(3) != 32'd0);
    ireq    <= hold_req ? 1'b0 : (rand_bits(2) != 32'd0);
  endtask

  // ordy read on an edge is the value settled after the previous edge
  task automatic wait_ready();
    do begin
      tick();
    end while (!ordy);
  endtask

  task automatic wait_drained();
    while (exp_frames.size() != 0) begin
      tick();
    end
  endtask

  task automatic send_frame(info_t bits, tag_t tag);
    in_strm_t beat;
    int       gap;
    wait_ready();
    exp_frames.push_back(polar_encode(place_bits(bits)));
    exp_tags.push_back(tag);
    frames_in++;
    for (int k = 0; k < `PC_K; k++) begin
      gap = int'(rand_bits(2));
      if (k > 0) begin
        istrm <= '0;
        repeat (gap) tick();
      end
      beat     = '0;
      beat.val = 1'b1;
      beat.sop = (k == 0);
      beat.eop = (k == `PC_K - 1);
      beat.dat = bits[k];
      // tag off the sop beat must be ignored
      beat.tag = (k == 0) ? tag : ~tag;
      istrm <= beat;
      // hold the beat until an enabled edge takes it
      do begin
        tick();
      end while (!en_seen);
    end
    istrm <= '0;
  endtask

  initial begin
    iclk     = 1'b0;
    ireset   = 1'b1;
    iclkena  = 1'b0;
    ireq     = 1'b0;
    istrm    = '0;
    hold_req = 1'b0;
    repeat (10) @(posedge iclk);
    ireset <= 1'b0;
    // corner frames first
    send_frame('0, tag_t'(rand_bits(`PC_TAG_W)));
    send_frame('1, tag_t'(rand_bits(`PC_TAG_W)));
    for (int f = 0; f < N_RAND; f++) begin
      send_frame(info_t'(rand_bits(`PC_K)), tag_t'(rand_bits(`PC_TAG_W)));
    end
    wait_drained();
    // no requests, both banks fill and the source backs up
    hold_req = 1'b1;
    for (int f = 0; f < N_HOLD; f++) begin
      send_frame(info_t'(rand_bits(`PC_K)), tag_t'(rand_bits(`PC_TAG_W)));
    end
    repeat (HOLD_TICKS) tick();
    check_bit(ordy, 1'b0, "ordy");
    check_bit(ofull, 1'b1, "ofull");
    hold_req = 1'b0;
    wait_drained();
    if (errors == 0 && frames_out == frames_in) begin
      $display("** PASS **");
      $finish;
    end else begin
      abort_run($sformatf("frames sent %0d but received %0d", frames_in, frames_out));
    end
  end

  // ------------------------------
  // output monitor
  // ------------------------------

  // a beat counts once, on the enabled edge that consumes it
  always @(posedge iclk) begin
    if (!ireset && iclkena && ostrm.val) begin
      if (hold_req) begin
        abort_run("output beat appeared while ireq was held low");
      end
      if (exp_frames.size() == 0) begin
        abort_run("output beat appeared with no frame outstanding");
      end
      check_bit(ostrm.sop, (beat_idx == 0), "osop");
      check_bit(ostrm.eop, (beat_idx == `PC_N - 1), "oeop");
      check_tag(ostrm.tag, exp_tags[0], "otag");
      got_vec[beat_idx] = ostrm.dat;
      if (beat_idx == `PC_N - 1) begin
        check_frame(got_vec, exp_frames[0], "oframe");
        void'(exp_frames.pop_front());
        void'(exp_tags.pop_front());
        frames_out++;
        beat_idx = 0;
      end else begin
        beat_idx++;
      end
    end
  end

  // ------------------------------
  // watchdog
  // ------------------------------

  initial begin
    #(WATCHDOG_CYCLES * 100);
    abort_run($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
  end

endmodule

//--- verilog.f
+incdir+.
pc_enc_code_pkg.sv
pc_enc_strm_pkg.sv
pc_enc_source.sv
pc_enc_transform.sv
pc_enc_buffer.sv
pc_enc_sink.sv
pc_enc_top.sv
pc_enc_sva.sv
tb_pc_enc.sv

//--- run.sh
#!/bin/sh
# build and run the polar encoder testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal -f verilog.f --top-module tb_pc_enc -Mdir obj_dir &&
./obj_dir/Vtb_pc_enc || exit 1
